// ==== dv/mem_slave_model.sv ====
/*
   behavioral memory slave for the slave agent testbench
   words alias on the address bits just above the byte lanes
   read data returns two cycles after acceptance, and writes are never answered
*/
`default_nettype none

module mem_slave_model #(
   parameter int words    = 16,
   parameter int wait_pct = 30,
   parameter int err_bit  = 8
) (
   input  logic                      clk,
   input  logic                      reset,
   input  slave_agent_pkg::mem_cmd_t cmd,
   output logic                      waitrequest,
   output slave_agent_pkg::mem_rsp_t rsp
);
   timeunit 1ns;
   timeprecision 100ps;
   import slave_agent_pkg::*;

   localparam int idx_w = $clog2(words);

   logic [data_w-1:0] mem [words];
   logic [idx_w-1:0]  idx;
   // first stage of the read pipeline, the second stage is rsp itself
   logic              s1_valid;
   logic [data_w-1:0] s1_data;
   resp_t             s1_status;

   assign idx = cmd.address[mask_bits +: idx_w];

   // every word starts with a value that depends on its whole index
   initial begin
      for (int i = 0; i < words; i++) begin
         mem[i] = data_w'(32'h9e3779b9 * (i + 1));
      end
   end

   always @(posedge clk or posedge reset) begin
      if (reset) begin
         waitrequest <= 1'b0;
         s1_valid    <= 1'b0;
         rsp         <= '0;
      end else begin
         // a fresh wait state decision for every cycle
         waitrequest       <= ($urandom_range(99) < wait_pct);
         s1_valid          <= cmd.read & ~waitrequest;
         s1_data           <= mem[idx];
         s1_status         <= cmd.address[err_bit] ? resp_slverr : resp_okay;
         rsp.readdatavalid <= s1_valid;
         rsp.readdata      <= s1_data;
         rsp.response      <= s1_status;
         // writes land under their byte enables, error region included
         for (int b = 0; b < be_w; b++) begin
            if (cmd.write && !waitrequest && cmd.byteenable[b]) begin
               mem[idx][8*b +: 8] <= cmd.writedata[8*b +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== dv/slave_agent_tb.sv ====
/*
   testbench for the slave agent with a behavioral memory slave
   expected answers come from a shadow memory kept in command order
   the run is bounded by a watchdog sized from the command count
*/
`default_nettype none

module slave_agent_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import slave_agent_pkg::*;

   localparam int clk_period = 10;
   localparam int mem_words  = 16;
   localparam int wait_pct   = 30;
   localparam int err_bit    = 8;
   localparam int n_random   = 200;
   // the directed tests stay well below 40 commands
   localparam int n_cmds     = 40 + n_random;
   localparam int idx_w      = $clog2(mem_words);

   logic clk;
   logic reset;
   logic cp_valid;
   cmd_pkt_t cp_data;
   logic cp_ready;
   mem_cmd_t m0_cmd;
   logic m0_waitrequest;
   mem_rsp_t m0_rsp;
   logic rp_valid;
   rsp_pkt_t rp_data;
   logic rp_ready;

   // word image of the slave memory as the commands should leave it
   logic [data_w-1:0] shadow [mem_words];
   rsp_pkt_t exp_q [$];
   rsp_pkt_t exp_head;
   logic exp_avail;
   int exp_count;
   int exp_total;
   int rsp_count;
   int errors;
   int rdy_pct;
   string test_name;

   // handshakes are captured in the middle of the cycle and applied at the next rising edge
   logic took_cmd;
   logic took_rsp;
   cmd_pkt_t cmd_seen;

   slave_agent_top u_dut (.*);

   mem_slave_model #(.words(mem_words), .wait_pct(wait_pct), .err_bit(err_bit)) u_mem (
      .clk         (clk),
      .reset       (reset),
      .cmd         (m0_cmd),
      .waitrequest (m0_waitrequest),
      .rsp         (m0_rsp)
   );

   always #(clk_period / 2) clk = ~clk;

   // the answer side takes a response in rdy_pct percent of the cycles
   always @(posedge clk) begin
      #1;
      rp_ready = ($urandom_range(99) < rdy_pct);
   end

   // ----------------------------------------------------------
   // reference model
   // ----------------------------------------------------------
   // an accepted command updates the shadow and may owe one answer
   function automatic void record_cmd(cmd_pkt_t c);
      rsp_pkt_t r;
      logic [idx_w-1:0] idx;
      // the word index ignores the byte-lane bits of the address
      idx = c.addr[mask_bits +: idx_w];
      r.byteen = c.byteen;
      r.addr = c.addr;
      r.write = c.write;
      r.posted = c.posted;
      // the answer goes back, so the ids trade places
      r.src_id = c.dest_id;
      r.dest_id = c.src_id;
      // writes and reads without lanes are answered with zero data and okay
      r.data = '0;
      r.status = resp_okay;
      if (c.read && c.byteen != '0) begin
         r.data = shadow[idx];
         r.status = c.addr[err_bit] ? resp_slverr : resp_okay;
      end
      // only the enabled byte lanes of a write reach memory
      for (int b = 0; b < be_w; b++) begin
         if (c.write && c.byteen[b]) begin
            shadow[idx][8*b +: 8] = c.data[8*b +: 8];
         end
      end
      // reads and non-posted writes owe exactly one answer
      if (c.read || (c.write && !c.posted)) begin
         exp_q.push_back(r);
         exp_total++;
      end
   endfunction

   // the DUT outputs are steady half a cycle after the inputs change
   always @(negedge clk) begin
      took_rsp = rp_valid && rp_ready;
      took_cmd = cp_valid && cp_ready;
      cmd_seen = cp_data;
   end

   // the answer leaves before a new command is counted on the same edge
   always @(posedge clk) begin
      if (!reset) begin
         if (took_rsp) begin
            rsp_count++;
            if (exp_q.size() > 0) begin
               void'(exp_q.pop_front());
            end
         end
         if (took_cmd) begin
            record_cmd(cmd_seen);
         end
         exp_count = exp_q.size();
         exp_avail = (exp_count > 0);
         exp_head = exp_avail ? exp_q[0] : '0;
      end
   end

   // ----------------------------------------------------------
   // checks
   // ----------------------------------------------------------
   // a response with nothing outstanding is a duplicate or a stray answer
   assert property (@(posedge clk) disable iff (reset) (rp_valid && rp_ready) |-> exp_avail)
   else begin
      errors++;
      $display("%s: a response arrived with no command outstanding", test_name);
   end

   // answers leave in command order, so each one matches the oldest expected
   assert property (@(posedge clk) disable iff (reset)
      (rp_valid && rp_ready && exp_avail) |-> rp_data == exp_head)
   else begin
      errors++;
      $display("FAIL %s expected %h actual %h", test_name,
               $sampled(exp_head), $sampled(rp_data));
   end

   // a full set of outstanding answers must stall the command stream
   assert property (@(posedge clk) disable iff (reset) (exp_count == pend_depth) |-> !cp_ready)
   else begin
      errors++;
      $display("FAIL %s expected cp_ready 0 actual %b", test_name, $sampled(cp_ready));
   end

   // the slave gets the word-aligned form of the command address
   assert property (@(posedge clk) disable iff (reset) (m0_cmd.read || m0_cmd.write) |->
      m0_cmd.address == (cp_data.addr & ~addr_w'(be_w - 1)))
   else begin
      errors++;
      $display("FAIL %s expected address %h actual %h", test_name,
               $sampled(cp_data.addr) & ~addr_w'(be_w - 1), $sampled(m0_cmd.address));
   end

   // an idle stream or a command without lanes leaves the slave bus quiet
   assert property (@(posedge clk) (!cp_valid || cp_data.byteen == '0) |->
      !(m0_cmd.read || m0_cmd.write))
   else begin
      errors++;
      $display("%s: the slave saw a cycle with no command or no byte enables", test_name);
   end

   assert property (@(posedge clk) $fell(reset) |-> !rp_valid)
   else begin
      errors++;
      $display("FAIL %s expected rp_valid 0 actual %b", test_name, $sampled(rp_valid));
   end

   // ----------------------------------------------------------
   // stimulus
   // ----------------------------------------------------------
   // holds one command on the stream until the agent takes it
   task automatic send_cmd(input logic rd, input logic wr, input logic posted,
                           input logic [addr_w-1:0] addr, input logic [be_w-1:0] be,
                           input logic [data_w-1:0] data);
      logic taken;
      cp_data = '{data, be, addr, rd, wr, posted, id_w'($urandom), id_w'($urandom)};
      cp_valid = 1'b1;
      // the command moves on the first edge that finds cp_ready high
      do begin
         @(negedge clk);
         taken = cp_ready;
         @(posedge clk);
      end while (!taken);
      #1;
      cp_valid = 1'b0;
   endtask

   // waits until every expected answer has come back
   task automatic drain();
      wait (exp_count == 0);
      repeat (2) @(posedge clk);
      #1;
   endtask

   initial begin : watchdog
      #(n_cmds * 50 * clk_period);
      $display("timeout: %0d answers still outstanding", exp_count);
      $display("Test failed");
      $finish;
   end

   initial begin : main
      int kind;
      void'($urandom(32'h57754476));
      clk = 1'b0;
      reset = 1'b1;
      cp_valid = 1'b0;
      cp_data = '0;
      rp_ready = 1'b1;
      rdy_pct = 100;
      exp_count = 0;
      exp_total = 0;
      rsp_count = 0;
      errors = 0;
      exp_avail = 1'b0;
      exp_head = '0;
      took_cmd = 1'b0;
      took_rsp = 1'b0;
      cmd_seen = '0;
      test_name = "reset";
      // same fill as the memory model, one value per word index
      for (int i = 0; i < mem_words; i++) begin
         shadow[i] = data_w'(32'h9e3779b9 * (i + 1));
      end
      repeat (3) @(posedge clk);
      #1 reset = 1'b0;
      repeat (3) @(posedge clk);
      #1;

      // reads at unaligned addresses with partial lanes and posted writes that answer nothing
      test_name = "write_read";
      for (int i = 0; i < 4; i++) send_cmd(0, 1, 0, 32'h10 + 4 * i, 4'hf, $urandom);
      for (int i = 0; i < 4; i++) send_cmd(1, 0, 0, 32'h11 + 4 * i + i[1:0], 4'h6, '0);
      send_cmd(0, 1, 1, 32'h22, 4'h3, 32'hcafe_f00d);
      send_cmd(0, 1, 1, 32'h27, 4'hc, 32'h1234_5678);
      send_cmd(1, 0, 0, 32'h20, 4'hf, '0);
      send_cmd(1, 0, 0, 32'h24, 4'hf, '0);
      drain();

      // the lane-less write must not disturb the word written just before it
      test_name = "zero_be";
      send_cmd(1, 0, 0, 32'h30, 4'h0, '0);
      send_cmd(0, 1, 0, 32'h34, 4'hf, 32'h5a5a_a5a5);
      send_cmd(0, 1, 0, 32'h34, 4'h0, 32'hffff_ffff);
      send_cmd(1, 0, 0, 32'h34, 4'hf, '0);
      drain();

      // address bit 8 selects the error region of the slave
      test_name = "err_region";
      send_cmd(0, 1, 0, 32'h108, 4'hf, 32'hdead_beef);
      send_cmd(1, 0, 0, 32'h108, 4'hf, '0);
      send_cmd(1, 0, 0, 32'h10c, 4'h9, '0);
      drain();

      // slow answer side so the queues fill and cp_ready falls
      test_name = "backpressure";
      rdy_pct = 40;
      for (int n = 0; n < n_random; n++) begin
         // half reads, then non-posted and posted writes
         kind = $urandom_range(3);
         send_cmd(kind < 2, kind >= 2, kind == 3, $urandom, be_w'($urandom), $urandom);
         if ($urandom_range(3) == 0) begin
            @(posedge clk);
            #1;
         end
      end
      rdy_pct = 100;
      drain();

      // lost answers and answers to posted writes both show up in the count
      test_name = "response_count";
      assert (rsp_count == exp_total)
      else begin
         errors++;
         $display("FAIL %s expected %0d actual %0d", test_name, exp_total, rsp_count);
      end
      $display("summary: %0d responses, %0d expected, %0d errors", rsp_count, exp_total, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
logic/slave_agent_pkg.sv
logic/sync_fifo.sv
logic/cmd_issue.sv
logic/resp_build.sv
logic/slave_agent_top.sv
dv/mem_slave_model.sv
dv/slave_agent_tb.sv

// ==== logic/cmd_issue.sv ====
/*
   command side of the slave agent, purely combinational
   posted writes never produce a pending entry, so they get no answer
   every command stalls while the pending queue is full, even ones that need no entry
*/
`default_nettype none

module cmd_issue (
   input  logic                         cp_valid,
   input  slave_agent_pkg::cmd_pkt_t    cp_data,
   output logic                         cp_ready,
   output slave_agent_pkg::mem_cmd_t    m0_cmd,
   input  logic                         m0_waitrequest,
   input  logic                         pend_full,
   output logic                         pend_push,
   output slave_agent_pkg::pend_t       pend_entry
);
   import slave_agent_pkg::*;

   // ----------------------------------------------------------
   // command decode
   // ----------------------------------------------------------
   // a command with no byte lanes enabled never reaches the slave
   logic suppress;
   // the agent has room to track whatever this command may need
   logic room;
   logic accept;
   // reads and non-posted writes both owe an answer
   logic needs_answer;

   assign suppress     = ~|cp_data.byteen;
   assign room         = ~pend_full;
   assign needs_answer = cp_data.read | (cp_data.write & ~cp_data.posted);

   // ----------------------------------------------------------
   // stream back-pressure
   // ----------------------------------------------------------
   // the slave wait state only matters for commands that are issued to it
   // a suppressed command completes locally in the same cycle
   assign cp_ready = room & (~m0_waitrequest | suppress);
   assign accept   = cp_valid & cp_ready;

   // ----------------------------------------------------------
   // memory cycle
   // ----------------------------------------------------------
   // read and write are qualified with room so that the slave never takes
   // a cycle which the command stream has not taken as well
   // They also follow cp_valid, so the bus is quiet while no command waits
   assign m0_cmd.read  = cp_valid & room & cp_data.read & ~suppress;
   assign m0_cmd.write = cp_valid & room & cp_data.write & ~suppress;

   // the slave is word addressed in bytes, so the lane bits are cleared
   assign m0_cmd.address    = {cp_data.addr[addr_w-1:mask_bits], {mask_bits{1'b0}}};
   assign m0_cmd.byteenable = cp_data.byteen;
   assign m0_cmd.writedata  = cp_data.data;

   // ----------------------------------------------------------
   // pending entry
   // ----------------------------------------------------------
   // the entry goes in on the same edge that the command is taken
   assign pend_push = accept & needs_answer;

   // the slave gives no write responses, so every non-posted write is
   // answered locally, as is a read that was never sent out
   assign pend_entry.synth   = (cp_data.read & suppress) |
                               (cp_data.write & ~cp_data.posted);
   assign pend_entry.write   = cp_data.write;
   assign pend_entry.posted  = cp_data.posted;
   assign pend_entry.src_id  = cp_data.src_id;
   assign pend_entry.dest_id = cp_data.dest_id;
   // the answer carries the address as the master sent it, unmasked
   assign pend_entry.addr    = cp_data.addr;
   assign pend_entry.byteen  = cp_data.byteen;

endmodule

`default_nettype wire

// ==== logic/resp_build.sv ====
/*
   answer side of the slave agent, purely combinational
   answers leave strictly in command order, one per pending entry
   a head that is not synthesized is always a read and waits for its data word
*/
`default_nettype none

module resp_build (
   input  slave_agent_pkg::pend_t    pend_head,
   input  logic                      pend_empty,
   output logic                      pend_pop,
   input  slave_agent_pkg::rdata_t   rd_head,
   input  logic                      rd_empty,
   output logic                      rd_pop,
   output logic                      rp_valid,
   output slave_agent_pkg::rsp_pkt_t rp_data,
   input  logic                      rp_ready
);
   import slave_agent_pkg::*;

   // the head transaction has everything it needs to answer
   logic head_ready;
   // an answer leaves on this edge
   logic xfer;
   // the head owes a read-data word from the slave
   logic wants_data;

   logic [data_w-1:0] ans_data;
   resp_t             ans_status;

   // ----------------------------------------------------------
   // head readiness
   // ----------------------------------------------------------
   // posted writes never enter the queue, so a head that is neither
   // synthesized nor a write is a read that was really issued
   assign wants_data = ~pend_head.synth & ~pend_head.write;

   // a synthesized head answers at once
   // a real read must wait until its word has landed in the data queue
   assign head_ready = ~pend_empty & (pend_head.synth | ~rd_empty);

   assign rp_valid = head_ready;
   assign xfer     = rp_valid & rp_ready;

   // ----------------------------------------------------------
   // queue pops
   // ----------------------------------------------------------
   // both heads stay put until the answer is taken, which keeps rp_data
   // stable while rp_ready is low
   assign pend_pop = xfer;
   // the data queue only moves for a read that used one of its words
   assign rd_pop   = xfer & wants_data;

   // ----------------------------------------------------------
   // data and status selection
   // ----------------------------------------------------------
   always_comb begin
      if (pend_head.synth) begin
         // suppressed reads return zero, writes carry no data at all
         ans_data   = '0;
         ans_status = resp_okay;
      end else begin
         ans_data   = rd_head.data;
         ans_status = rd_head.status;
      end
   end

   // ----------------------------------------------------------
   // response packet
   // ----------------------------------------------------------
   // the answer travels back to the master, so source and destination trade places
   assign rp_data.src_id  = pend_head.dest_id;
   assign rp_data.dest_id = pend_head.src_id;

   // address and lanes go back exactly as they came in
   assign rp_data.addr    = pend_head.addr;
   assign rp_data.byteen  = pend_head.byteen;

   // transaction flags let the master tell a read answer from a write answer
   assign rp_data.write   = pend_head.write;
   assign rp_data.posted  = pend_head.posted;

   assign rp_data.data    = ans_data;
   assign rp_data.status  = ans_status;

endmodule

`default_nettype wire

// ==== logic/slave_agent_pkg.sv ====
/*
   shared widths, response codes and packet types of the slave agent
   be_w and mask_bits are derived from data_w, which must be a power-of-two
   multiple of 8 bits. Packet fields are packed with data at the top end.
*/
`default_nettype none

package slave_agent_pkg;

   // ----------------------------------------------------------
   // widths and sizes
   // ----------------------------------------------------------
   localparam int data_w     = 32;
   localparam int be_w       = data_w / 8;
   localparam int addr_w     = 32;
   localparam int id_w       = 3;
   // low address bits that pick a byte lane inside one word
   localparam int mask_bits  = $clog2(be_w);
   // depth of the pending queue and of the read-data queue
   // this is also the bound on reads outstanding at the slave
   localparam int pend_depth = 4;

   // ----------------------------------------------------------
   // response status codes
   // ----------------------------------------------------------
   typedef logic [1:0] resp_t;

   localparam resp_t resp_okay   = 2'b00;
   localparam resp_t resp_slverr = 2'b10;

   // ----------------------------------------------------------
   // packet and cycle types
   // ----------------------------------------------------------
   // single-beat command as it arrives on the command stream
   typedef struct packed {
      logic [data_w-1:0] data;
      logic [be_w-1:0]   byteen;
      logic [addr_w-1:0] addr;
      logic              read;
      logic              write;
      logic              posted;
      logic [id_w-1:0]   src_id;
      logic [id_w-1:0]   dest_id;
   } cmd_pkt_t;

   // answer packet, the ids are already swapped when it is built
   typedef struct packed {
      logic [data_w-1:0] data;
      logic [be_w-1:0]   byteen;
      logic [addr_w-1:0] addr;
      logic              write;
      logic              posted;
      logic [id_w-1:0]   src_id;
      logic [id_w-1:0]   dest_id;
      resp_t             status;
   } rsp_pkt_t;

   // read or write cycle as the memory slave sees it
   typedef struct packed {
      logic [addr_w-1:0] address;
      logic [be_w-1:0]   byteenable;
      logic              read;
      logic              write;
      logic [data_w-1:0] writedata;
   } mem_cmd_t;

   // return path from the slave, which only carries read data
   typedef struct packed {
      logic [data_w-1:0] readdata;
      logic              readdatavalid;
      resp_t             response;
   } mem_rsp_t;

   // one command that still owes an answer
   // synth set means the answer is made up locally and takes no read data
   typedef struct packed {
      logic              synth;
      logic              write;
      logic              posted;
      logic [id_w-1:0]   src_id;
      logic [id_w-1:0]   dest_id;
      logic [addr_w-1:0] addr;
      logic [be_w-1:0]   byteen;
   } pend_t;

   // one word of read data with its status
   typedef struct packed {
      logic [data_w-1:0] data;
      resp_t             status;
   } rdata_t;

endpackage

`default_nettype wire

// ==== logic/slave_agent_top.sv ====
/*
   memory-mapped slave agent, single-beat commands in and answers out
   the slave must return read data in order and no write responses
   at most pend_depth answers are outstanding, so the read-data queue cannot overflow
*/
`default_nettype none

module slave_agent_top (
   input  logic                         clk,
   input  logic                         reset,
   // command stream
   input  logic                         cp_valid,
   input  slave_agent_pkg::cmd_pkt_t    cp_data,
   output logic                         cp_ready,
   // memory slave
   output slave_agent_pkg::mem_cmd_t    m0_cmd,
   input  logic                         m0_waitrequest,
   input  slave_agent_pkg::mem_rsp_t    m0_rsp,
   // response stream
   output logic                         rp_valid,
   output slave_agent_pkg::rsp_pkt_t    rp_data,
   input  logic                         rp_ready
);
   import slave_agent_pkg::*;

   // ----------------------------------------------------------
   // internal wires
   // ----------------------------------------------------------
   logic   pend_push;
   pend_t  pend_entry;
   logic   pend_pop;
   pend_t  pend_head;
   logic   pend_empty;
   logic   pend_full;

   rdata_t rd_entry;
   logic   rd_pop;
   rdata_t rd_head;
   logic   rd_empty;

   // read data is captured on every readdatavalid without any handshake
   assign rd_entry.data   = m0_rsp.readdata;
   assign rd_entry.status = m0_rsp.response;

   // ----------------------------------------------------------
   // command issue
   // ----------------------------------------------------------
   cmd_issue u_cmd_issue (
      .cp_valid       (cp_valid),
      .cp_data        (cp_data),
      .cp_ready       (cp_ready),
      .m0_cmd         (m0_cmd),
      .m0_waitrequest (m0_waitrequest),
      .pend_full      (pend_full),
      .pend_push      (pend_push),
      .pend_entry     (pend_entry)
   );

   // ----------------------------------------------------------
   // queues
   // ----------------------------------------------------------
   // in-order record of every command that owes an answer
   sync_fifo #(.entry_t(pend_t), .depth(pend_depth)) u_pend_fifo (
      .clk   (clk),
      .reset (reset),
      .push  (pend_push),
      .wdata (pend_entry),
      .pop   (pend_pop),
      .rdata (pend_head),
      .empty (pend_empty),
      .full  (pend_full)
   );

   // the pending queue limits reads in flight, so this one never fills
   sync_fifo #(.entry_t(rdata_t), .depth(pend_depth)) u_rdata_fifo (
      .clk   (clk),
      .reset (reset),
      .push  (m0_rsp.readdatavalid),
      .wdata (rd_entry),
      .pop   (rd_pop),
      .rdata (rd_head),
      .empty (rd_empty),
      .full  ()
   );

   // ----------------------------------------------------------
   // response build
   // ----------------------------------------------------------
   resp_build u_resp_build (
      .pend_head  (pend_head),
      .pend_empty (pend_empty),
      .pend_pop   (pend_pop),
      .rd_head    (rd_head),
      .rd_empty   (rd_empty),
      .rd_pop     (rd_pop),
      .rp_valid   (rp_valid),
      .rp_data    (rp_data),
      .rp_ready   (rp_ready)
   );

endmodule

`default_nettype wire

// ==== logic/sync_fifo.sv ====
/*
   single-clock circular FIFO with a combinational head
   depth must be at least 2. A push while full is dropped unless a pop
   happens in the same cycle, and a pop while empty is ignored.
*/
`default_nettype none

module sync_fifo #(
   parameter type entry_t = logic [7:0],
   parameter int  depth   = 4
) (
   input  logic   clk,
   input  logic   reset,
   input  logic   push,
   input  entry_t wdata,
   input  logic   pop,
   output entry_t rdata,
   output logic   empty,
   output logic   full
);

   typedef logic [$clog2(depth)-1:0]   ptr_t;
   typedef logic [$clog2(depth+1)-1:0] cnt_t;

   // storage keeps no reset, only the pointers and the count are control state
   entry_t mem [depth];

   ptr_t wr_ptr;
   ptr_t rd_ptr;
   cnt_t count;

   logic do_push;
   logic do_pop;

   // ----------------------------------------------------------
   // status and qualified strobes
   // ----------------------------------------------------------
   assign empty = (count == '0);
   assign full  = (count == cnt_t'(depth));

   // a full queue still takes a push when the head leaves on the same edge
   assign do_pop  = pop & ~empty;
   assign do_push = push & (~full | pop);

   // the head is visible as soon as the entry has been written
   assign rdata = mem[rd_ptr];

   // ----------------------------------------------------------
   // pointers and occupancy
   // ----------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // pointers wrap by compare, so depth need not be a power of two
         if (do_push) begin
            wr_ptr <= (wr_ptr == ptr_t'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == ptr_t'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // ----------------------------------------------------------
   // storage
   // ----------------------------------------------------------
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= wdata;
      end
   end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# builds the slave agent testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f \
   --top-module slave_agent_tb -o slave_agent_sim

out=$(./obj_dir/slave_agent_sim)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
   exit 0
else
   exit 1
fi
